// File: pipe_regfile.f
source/pipe_regfile_pkg.sv
source/instr_queue.sv
source/issue_stage.sv
source/register_file.sv
source/alu_stage.sv
source/mem_wb_stage.sv
source/pipe_regfile_top.sv
bench/pipe_regfile_tb.sv

// File: Bender.yml
package:
  name: pipe_regfile

sources:
  - source/pipe_regfile_pkg.sv
  - source/instr_queue.sv
  - source/issue_stage.sv
  - source/register_file.sv
  - source/alu_stage.sv
  - source/mem_wb_stage.sv
  - source/pipe_regfile_top.sv
  - target: simulation
    files:
      - bench/pipe_regfile_tb.sv

// File: bench/pipe_regfile_tb.sv
module pipe_regfile_tb
    import pipe_regfile_pkg::*;
();

    localparam int NUM_DIRECTED = 29;
    localparam int NUM_RANDOM   = 300;
    localparam int CLK_PERIOD   = 10;
    // Generous per-instruction budget, hazards included
    localparam int LIMIT_CYCLES = (NUM_DIRECTED + NUM_RANDOM) * 20;
    localparam int EXP_SLOTS    = 1024;

    logic                  clk_i = 1'b0;
    logic                  rst_i;
    logic                  in_valid_i;
    opcode_e               in_op_i;
    logic [REG_ADDR_W-1:0] in_rd_i;
    logic [REG_ADDR_W-1:0] in_rs1_i;
    logic [REG_ADDR_W-1:0] in_rs2_i;
    logic [IMM_W-1:0]      in_imm_i;
    logic                  credit_o;
    logic                  wb_valid_o;
    logic [REG_ADDR_W-1:0] wb_rd_o;
    logic [XLEN-1:0]       wb_data_o;

    // Reference machine state
    logic [XLEN-1:0]       model_regs [NUM_REGS];
    logic [XLEN-1:0]       model_mem  [MEM_WORDS];

    // Expected retire trace, head moves on each wb_valid_o beat
    logic [REG_ADDR_W-1:0] exp_rd   [EXP_SLOTS];
    logic [XLEN-1:0]       exp_data [EXP_SLOTS];
    int                    exp_head = 0;
    int                    exp_tail = 0;

    int                    accepted = 0;
    int                    returned = 0;
    int                    seed     = 32'hc954;
    string                 test_name;

    pipe_regfile_top i_dut (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .in_valid_i (in_valid_i),
        .in_op_i    (in_op_i),
        .in_rd_i    (in_rd_i),
        .in_rs1_i   (in_rs1_i),
        .in_rs2_i   (in_rs2_i),
        .in_imm_i   (in_imm_i),
        .credit_o   (credit_o),
        .wb_valid_o (wb_valid_o),
        .wb_rd_o    (wb_rd_o),
        .wb_data_o  (wb_data_o)
    );

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    // Credits coming back from the queue
    always @(posedge clk_i) begin
        if (rst_i && credit_o) begin
            returned <= returned + 1;
        end
    end

    // Retired beat consumes one expectation
    always @(posedge clk_i) begin
        if (rst_i && wb_valid_o) begin
            exp_head <= exp_head + 1;
        end
    end

    task automatic fail_run(input string line);
        $display("%s", line);
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    // ------------------------------
    // Checkers
    // ------------------------------
    a_quiet_reset: assert property (@(posedge clk_i)
        !rst_i |=> (!credit_o && !wb_valid_o))
        else fail_run("credit_o or wb_valid_o went high during reset");

    a_retire_expected: assert property (@(posedge clk_i) disable iff (!rst_i)
        wb_valid_o |-> (exp_head != exp_tail))
        else fail_run("a register write retired with no instruction expecting it");

    a_retire_value: assert property (@(posedge clk_i) disable iff (!rst_i)
        (wb_valid_o && (exp_head != exp_tail)) |->
            ((wb_rd_o == exp_rd[exp_head]) && (wb_data_o == exp_data[exp_head])))
        else fail_run($sformatf("error: test %s expected rd %0d data %h, actual rd %0d data %h",
                                test_name, exp_rd[$sampled(exp_head)],
                                exp_data[$sampled(exp_head)],
                                $sampled(wb_rd_o), $sampled(wb_data_o)));

    // Queue never hands back a credit for a slot it was not given
    a_credit_bound: assert property (@(posedge clk_i) disable iff (!rst_i)
        returned <= accepted)
        else fail_run("queue returned more credits than instructions it accepted");

    // Watchdog
    initial begin
        repeat (LIMIT_CYCLES + 10) @(posedge clk_i);
        fail_run("watchdog expired before the run reached its end");
    end

    // ------------------------------
    // Reference model
    // ------------------------------
    task automatic model_exec(input opcode_e op, input logic [REG_ADDR_W-1:0] rd,
                              input logic [REG_ADDR_W-1:0] rs1,
                              input logic [REG_ADDR_W-1:0] rs2,
                              input logic [IMM_W-1:0] imm);
        logic [XLEN-1:0]       a;
        logic [XLEN-1:0]       b;
        logic [XLEN-1:0]       ea;
        logic [XLEN-1:0]       res;
        logic [MEM_ADDR_W-1:0] addr;
        logic                  writes;
        a      = model_regs[rs1];
        b      = model_regs[rs2];
        ea     = a + {{(XLEN-IMM_W){imm[IMM_W-1]}}, imm};
        addr   = ea[MEM_ADDR_W-1:0];
        res    = '0;
        writes = 1'b1;
        case (op)
            OP_ADD:  res = a + b;
            OP_SUB:  res = a - b;
            OP_AND:  res = a & b;
            OP_XOR:  res = a ^ b;
            OP_ADDI: res = ea;
            OP_LOAD: res = model_mem[addr];
            OP_STORE: begin
                model_mem[addr] = b;
                writes          = 1'b0;
            end
            default: writes = 1'b0;
        endcase
        if (writes) begin
            exp_rd[exp_tail]   = rd;
            exp_data[exp_tail] = res;
            exp_tail++;
            // r0 retires its value but keeps reading zero
            if (rd != '0) begin
                model_regs[rd] = res;
            end
        end
    endtask

    // ------------------------------
    // Stimulus
    // ------------------------------
    task automatic send_instr(input opcode_e op, input logic [REG_ADDR_W-1:0] rd,
                              input logic [REG_ADDR_W-1:0] rs1,
                              input logic [REG_ADDR_W-1:0] rs2,
                              input logic [IMM_W-1:0] imm);
        // Hold off until a credit is available
        while ((accepted - returned) >= QUEUE_DEPTH) begin
            @(posedge clk_i);
            #1;
        end
        in_valid_i = 1'b1;
        in_op_i    = op;
        in_rd_i    = rd;
        in_rs1_i   = rs1;
        in_rs2_i   = rs2;
        in_imm_i   = imm;
        model_exec(op, rd, rs1, rs2, imm);
        accepted++;
        @(posedge clk_i);
        #1;
        in_valid_i = 1'b0;
    endtask

    // All credits home, then the last op leaves WB
    task automatic drain_pipe();
        while (returned != accepted) begin
            @(posedge clk_i);
            #1;
        end
        repeat (3) begin
            @(posedge clk_i);
            #1;
        end
    endtask

    task automatic run_random();
        int      r;
        opcode_e op;
        for (int n = 0; n < NUM_RANDOM; n++) begin
            r  = $random(seed);
            op = opcode_e'(r[2:0]);
            // Registers 0 to 7 only, so hazards are frequent
            send_instr(op, {2'b00, r[5:3]}, {2'b00, r[8:6]}, {2'b00, r[11:9]}, r[23:12]);
            if (r[26:24] == 3'd0) begin
                @(posedge clk_i);
                #1;
            end
        end
    endtask

    initial begin
        rst_i      = 1'b0;
        in_valid_i = 1'b0;
        in_op_i    = OP_NOP;
        in_rd_i    = '0;
        in_rs1_i   = '0;
        in_rs2_i   = '0;
        in_imm_i   = '0;
        test_name  = "reset";
        for (int i = 0; i < NUM_REGS; i++) begin
            model_regs[i] = '0;
        end
        for (int i = 0; i < MEM_WORDS; i++) begin
            model_mem[i] = '0;
        end
        repeat (10) @(posedge clk_i);
        #1;
        rst_i = 1'b1;
        repeat (3) begin
            assert (!credit_o && !wb_valid_o)
                else fail_run("credit_o or wb_valid_o went high right after reset");
            @(posedge clk_i);
            #1;
        end

        // Independent ALU ops on seeded registers
        test_name = "independent";
        send_instr(OP_ADDI, 5'd1, 5'd0, 5'd0, 12'h123);
        send_instr(OP_ADDI, 5'd2, 5'd0, 5'd0, 12'hff9);
        send_instr(OP_ADDI, 5'd4, 5'd0, 5'd0, 12'h7ff);
        send_instr(OP_ADDI, 5'd5, 5'd0, 5'd0, 12'h800);
        send_instr(OP_ADD,  5'd6, 5'd1, 5'd2, 12'h000);
        send_instr(OP_SUB,  5'd7, 5'd4, 5'd5, 12'h000);
        send_instr(OP_AND,  5'd8, 5'd1, 5'd4, 12'h000);
        send_instr(OP_XOR,  5'd9, 5'd2, 5'd5, 12'h000);
        drain_pipe();

        // Back to back, each op reads the previous ones
        test_name = "dependent_chain";
        send_instr(OP_ADDI, 5'd10, 5'd0,  5'd0,  12'h001);
        send_instr(OP_ADD,  5'd11, 5'd10, 5'd10, 12'h000);
        send_instr(OP_ADD,  5'd12, 5'd11, 5'd10, 12'h000);
        send_instr(OP_SUB,  5'd13, 5'd12, 5'd11, 12'h000);
        send_instr(OP_XOR,  5'd14, 5'd13, 5'd12, 12'h000);
        send_instr(OP_AND,  5'd15, 5'd14, 5'd13, 12'h000);
        send_instr(OP_ADDI, 5'd15, 5'd15, 5'd0,  12'h003);
        drain_pipe();

        // Store then load, and a load consumed right away
        test_name = "load_store";
        send_instr(OP_ADDI,  5'd16, 5'd0,  5'd0,  12'h005);
        send_instr(OP_STORE, 5'd0,  5'd16, 5'd12, 12'h002);
        send_instr(OP_LOAD,  5'd17, 5'd16, 5'd0,  12'h002);
        send_instr(OP_ADD,   5'd18, 5'd17, 5'd17, 12'h000);
        send_instr(OP_LOAD,  5'd19, 5'd0,  5'd0,  12'h007);
        send_instr(OP_SUB,   5'd20, 5'd19, 5'd1,  12'h000);
        send_instr(OP_STORE, 5'd0,  5'd0,  5'd20, 12'hfff);
        send_instr(OP_LOAD,  5'd21, 5'd0,  5'd0,  12'h00f);
        drain_pipe();

        // Writes to r0 retire, reads of r0 stay zero
        test_name = "reg_zero";
        send_instr(OP_ADDI, 5'd0,  5'd1,  5'd0, 12'h005);
        send_instr(OP_ADD,  5'd0,  5'd2,  5'd2, 12'h000);
        send_instr(OP_ADD,  5'd22, 5'd0,  5'd1, 12'h000);
        send_instr(OP_LOAD, 5'd0,  5'd16, 5'd0, 12'h002);
        send_instr(OP_SUB,  5'd23, 5'd0,  5'd0, 12'h000);
        send_instr(OP_AND,  5'd24, 5'd0,  5'd1, 12'h000);
        drain_pipe();

        test_name = "random";
        run_random();
        drain_pipe();

        if ((exp_head == exp_tail) && (returned == accepted)) begin
            $display("ALL CHECKS PASSED");
            $finish;
        end else begin
            fail_run($sformatf("idle with %0d writes not retired and %0d of %0d credits back",
                               exp_tail - exp_head, returned, accepted));
        end
    end

endmodule

// File: source/pipe_regfile_top.sv
module pipe_regfile_top
    import pipe_regfile_pkg::*;
(
    input  logic                  clk_i,
    input  logic                  rst_i,
    input  logic                  in_valid_i,
    input  opcode_e               in_op_i,
    input  logic [REG_ADDR_W-1:0] in_rd_i,
    input  logic [REG_ADDR_W-1:0] in_rs1_i,
    input  logic [REG_ADDR_W-1:0] in_rs2_i,
    input  logic [IMM_W-1:0]      in_imm_i,
    output logic                  credit_o,
    output logic                  wb_valid_o,
    output logic [REG_ADDR_W-1:0] wb_rd_o,
    output logic [XLEN-1:0]       wb_data_o
);

    // Queue head
    logic                  q_valid;
    opcode_e               q_op;
    logic [REG_ADDR_W-1:0] q_rd;
    logic [REG_ADDR_W-1:0] q_rs1;
    logic [REG_ADDR_W-1:0] q_rs2;
    logic [IMM_W-1:0]      q_imm;
    logic                  q_pop;

    // Issue to register file
    logic                  rd_rs1_en;
    logic                  rd_rs2_en;
    logic [REG_ADDR_W-1:0] rs1_idx;
    logic [REG_ADDR_W-1:0] rs2_idx;
    logic [XLEN-1:0]       rs1_data;
    logic [XLEN-1:0]       rs2_data;
    logic                  stall;
    logic                  alloc_en;
    logic [REG_ADDR_W-1:0] alloc_rd;

    // Issue to ALU
    logic                  iss_valid;
    opcode_e               iss_op;
    logic [REG_ADDR_W-1:0] iss_rd;
    logic [XLEN-1:0]       iss_a;
    logic [XLEN-1:0]       iss_b;
    logic [IMM_W-1:0]      iss_imm;

    // ------------------------------
    // Execute and memory outputs
    // ------------------------------
    logic                  ex_valid;
    opcode_e               ex_op;
    logic [REG_ADDR_W-1:0] ex_rd;
    logic [XLEN-1:0]       ex_result;
    logic [XLEN-1:0]       ex_store_data;
    logic                  ex_fwd_en;
    logic                  ex_fwd_is_load;
    logic                  mem_fwd_en;
    logic [REG_ADDR_W-1:0] mem_fwd_rd;
    logic [XLEN-1:0]       mem_fwd_data;

    instr_queue i_instr_queue (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .in_valid_i   (in_valid_i),
        .in_op_i      (in_op_i),
        .in_rd_i      (in_rd_i),
        .in_rs1_i     (in_rs1_i),
        .in_rs2_i     (in_rs2_i),
        .in_imm_i     (in_imm_i),
        .pop_i        (q_pop),
        .head_valid_o (q_valid),
        .head_op_o    (q_op),
        .head_rd_o    (q_rd),
        .head_rs1_o   (q_rs1),
        .head_rs2_o   (q_rs2),
        .head_imm_o   (q_imm),
        .credit_o     (credit_o)
    );

    issue_stage i_issue_stage (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .head_valid_i (q_valid),
        .head_op_i    (q_op),
        .head_rd_i    (q_rd),
        .head_rs1_i   (q_rs1),
        .head_rs2_i   (q_rs2),
        .head_imm_i   (q_imm),
        .pop_o        (q_pop),
        .rd_rs1_en_o  (rd_rs1_en),
        .rd_rs2_en_o  (rd_rs2_en),
        .rs1_idx_o    (rs1_idx),
        .rs2_idx_o    (rs2_idx),
        .rs1_data_i   (rs1_data),
        .rs2_data_i   (rs2_data),
        .stall_i      (stall),
        .alloc_en_o   (alloc_en),
        .alloc_rd_o   (alloc_rd),
        .iss_valid_o  (iss_valid),
        .iss_op_o     (iss_op),
        .iss_rd_o     (iss_rd),
        .iss_a_o      (iss_a),
        .iss_b_o      (iss_b),
        .iss_imm_o    (iss_imm)
    );

    register_file i_register_file (
        .clk_i            (clk_i),
        .rst_i            (rst_i),
        .rd_rs1_en_i      (rd_rs1_en),
        .rd_rs2_en_i      (rd_rs2_en),
        .rs1_idx_i        (rs1_idx),
        .rs2_idx_i        (rs2_idx),
        .rs1_data_o       (rs1_data),
        .rs2_data_o       (rs2_data),
        .stall_o          (stall),
        .alloc_en_i       (alloc_en),
        .alloc_rd_i       (alloc_rd),
        .ex_fwd_en_i      (ex_fwd_en),
        .ex_fwd_rd_i      (ex_rd),
        .ex_fwd_is_load_i (ex_fwd_is_load),
        .ex_fwd_data_i    (ex_result),
        .mem_fwd_en_i     (mem_fwd_en),
        .mem_fwd_rd_i     (mem_fwd_rd),
        .mem_fwd_data_i   (mem_fwd_data),
        .wb_en_i          (wb_valid_o),
        .wb_rd_i          (wb_rd_o),
        .wb_data_i        (wb_data_o)
    );

    alu_stage i_alu_stage (
        .clk_i            (clk_i),
        .rst_i            (rst_i),
        .iss_valid_i      (iss_valid),
        .iss_op_i         (iss_op),
        .iss_rd_i         (iss_rd),
        .iss_a_i          (iss_a),
        .iss_b_i          (iss_b),
        .iss_imm_i        (iss_imm),
        .ex_valid_o       (ex_valid),
        .ex_op_o          (ex_op),
        .ex_rd_o          (ex_rd),
        .ex_result_o      (ex_result),
        .ex_store_data_o  (ex_store_data),
        .ex_fwd_en_o      (ex_fwd_en),
        .ex_fwd_is_load_o (ex_fwd_is_load)
    );

    // WB register drives both the write port and the retire trace
    mem_wb_stage i_mem_wb_stage (
        .clk_i           (clk_i),
        .rst_i           (rst_i),
        .ex_valid_i      (ex_valid),
        .ex_op_i         (ex_op),
        .ex_rd_i         (ex_rd),
        .ex_result_i     (ex_result),
        .ex_store_data_i (ex_store_data),
        .mem_fwd_en_o    (mem_fwd_en),
        .mem_fwd_rd_o    (mem_fwd_rd),
        .mem_fwd_data_o  (mem_fwd_data),
        .wb_en_o         (wb_valid_o),
        .wb_rd_o         (wb_rd_o),
        .wb_data_o       (wb_data_o)
    );

endmodule

// File: source/mem_wb_stage.sv
module mem_wb_stage
    import pipe_regfile_pkg::*;
(
    input  logic                  clk_i,
    input  logic                  rst_i,
    input  logic                  ex_valid_i,
    input  opcode_e               ex_op_i,
    input  logic [REG_ADDR_W-1:0] ex_rd_i,
    input  logic [XLEN-1:0]       ex_result_i,
    input  logic [XLEN-1:0]       ex_store_data_i,
    output logic                  mem_fwd_en_o,
    output logic [REG_ADDR_W-1:0] mem_fwd_rd_o,
    output logic [XLEN-1:0]       mem_fwd_data_o,
    output logic                  wb_en_o,
    output logic [REG_ADDR_W-1:0] wb_rd_o,
    output logic [XLEN-1:0]       wb_data_o
);

    logic                  mem_valid;
    opcode_e               mem_op;
    logic [REG_ADDR_W-1:0] mem_rd;
    logic [XLEN-1:0]       mem_result;
    logic [XLEN-1:0]       mem_store_data;

    logic [XLEN-1:0]       scratch [MEM_WORDS];
    logic [MEM_ADDR_W-1:0] mem_addr;
    logic [XLEN-1:0]       load_data;

    // ------------------------------
    // MEM pipeline register
    // ------------------------------
    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            mem_valid <= 1'b0;
            mem_op    <= OP_NOP;
        end else begin
            mem_valid <= ex_valid_i;
            mem_op    <= ex_op_i;
        end
    end

    always_ff @(posedge clk_i) begin
        mem_rd         <= ex_rd_i;
        mem_result     <= ex_result_i;
        mem_store_data <= ex_store_data_i;
    end

    // Word address from low bits of the sum
    assign mem_addr  = mem_result[MEM_ADDR_W-1:0];
    assign load_data = scratch[mem_addr];

    // Scratch words start at zero, store lands at end of MEM
    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            for (int i = 0; i < MEM_WORDS; i++) begin
                scratch[i] <= '0;
            end
        end else if (mem_valid && (mem_op == OP_STORE)) begin
            scratch[mem_addr] <= mem_store_data;
        end
    end

    // Load data ready here for forwarding
    assign mem_fwd_en_o   = mem_valid && op_writes_rd(mem_op);
    assign mem_fwd_rd_o   = mem_rd;
    assign mem_fwd_data_o = (mem_op == OP_LOAD) ? load_data : mem_result;

    // ------------------------------
    // WB register, also the retire trace
    // ------------------------------
    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            wb_en_o <= 1'b0;
        end else begin
            wb_en_o <= mem_fwd_en_o;
        end
    end

    always_ff @(posedge clk_i) begin
        wb_rd_o   <= mem_fwd_rd_o;
        wb_data_o <= mem_fwd_data_o;
    end

endmodule

// File: source/alu_stage.sv
module alu_stage
    import pipe_regfile_pkg::*;
(
    input  logic                  clk_i,
    input  logic                  rst_i,
    input  logic                  iss_valid_i,
    input  opcode_e               iss_op_i,
    input  logic [REG_ADDR_W-1:0] iss_rd_i,
    input  logic [XLEN-1:0]       iss_a_i,
    input  logic [XLEN-1:0]       iss_b_i,
    input  logic [IMM_W-1:0]      iss_imm_i,
    output logic                  ex_valid_o,
    output opcode_e               ex_op_o,
    output logic [REG_ADDR_W-1:0] ex_rd_o,
    output logic [XLEN-1:0]       ex_result_o,
    output logic [XLEN-1:0]       ex_store_data_o,
    output logic                  ex_fwd_en_o,
    output logic                  ex_fwd_is_load_o
);

    logic                  valid_r;
    opcode_e               op_r;
    logic [REG_ADDR_W-1:0] rd_r;
    logic [XLEN-1:0]       a_r;
    logic [XLEN-1:0]       b_r;
    logic [IMM_W-1:0]      imm_r;
    logic [XLEN-1:0]       imm_sext;

    // ------------------------------
    // EX pipeline register
    // ------------------------------
    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            valid_r <= 1'b0;
            op_r    <= OP_NOP;
        end else begin
            valid_r <= iss_valid_i;
            op_r    <= iss_op_i;
        end
    end

    // Operands and destination
    always_ff @(posedge clk_i) begin
        rd_r  <= iss_rd_i;
        a_r   <= iss_a_i;
        b_r   <= iss_b_i;
        imm_r <= iss_imm_i;
    end

    assign imm_sext = {{(XLEN-IMM_W){imm_r[IMM_W-1]}}, imm_r};

    // ALU result or effective address
    always_comb begin
        case (op_r)
            OP_ADD:                      ex_result_o = a_r + b_r;
            OP_SUB:                      ex_result_o = a_r - b_r;
            OP_AND:                      ex_result_o = a_r & b_r;
            OP_XOR:                      ex_result_o = a_r ^ b_r;
            OP_ADDI, OP_LOAD, OP_STORE:  ex_result_o = a_r + imm_sext;
            default:                     ex_result_o = '0;
        endcase
    end

    assign ex_valid_o      = valid_r;
    assign ex_op_o         = op_r;
    assign ex_rd_o         = rd_r;
    assign ex_store_data_o = b_r;

    // Loads have only an address here, so no forward
    assign ex_fwd_en_o      = valid_r && op_writes_rd(op_r);
    assign ex_fwd_is_load_o = valid_r && (op_r == OP_LOAD);

endmodule

// File: source/register_file.sv
module register_file
    import pipe_regfile_pkg::*;
(
    input  logic                  clk_i,
    input  logic                  rst_i,
    input  logic                  rd_rs1_en_i,
    input  logic                  rd_rs2_en_i,
    input  logic [REG_ADDR_W-1:0] rs1_idx_i,
    input  logic [REG_ADDR_W-1:0] rs2_idx_i,
    output logic [XLEN-1:0]       rs1_data_o,
    output logic [XLEN-1:0]       rs2_data_o,
    output logic                  stall_o,
    input  logic                  alloc_en_i,
    input  logic [REG_ADDR_W-1:0] alloc_rd_i,
    input  logic                  ex_fwd_en_i,
    input  logic [REG_ADDR_W-1:0] ex_fwd_rd_i,
    input  logic                  ex_fwd_is_load_i,
    input  logic [XLEN-1:0]       ex_fwd_data_i,
    input  logic                  mem_fwd_en_i,
    input  logic [REG_ADDR_W-1:0] mem_fwd_rd_i,
    input  logic [XLEN-1:0]       mem_fwd_data_i,
    input  logic                  wb_en_i,
    input  logic [REG_ADDR_W-1:0] wb_rd_i,
    input  logic [XLEN-1:0]       wb_data_i
);

    logic [XLEN-1:0]   regs [NUM_REGS];
    // Writes still in flight per register
    logic [PEND_W-1:0] pend [NUM_REGS];

    logic rs1_ready;
    logic rs2_ready;
    logic inc_en;
    logic dec_en;
    logic same_rd;

    // ------------------------------
    // Operand select
    // ------------------------------
    // Returns {ready, data}, file first then EX then MEM
    function automatic logic [XLEN:0] pick_operand(
        input logic                  en,
        input logic [REG_ADDR_W-1:0] idx,
        input logic [PEND_W-1:0]     cnt,
        input logic [XLEN-1:0]       file_val
    );
        logic          ex_hit;
        logic          mem_hit;
        logic [XLEN:0] res;
        ex_hit  = ex_fwd_en_i && (ex_fwd_rd_i == idx);
        mem_hit = mem_fwd_en_i && (mem_fwd_rd_i == idx);
        res     = '0;
        if (!en) begin
            res = '0;
        end else if (cnt == '0) begin
            res = {1'b1, file_val};
        end else if (ex_hit && !ex_fwd_is_load_i) begin
            res = {1'b1, ex_fwd_data_i};
        end else if (mem_hit && !ex_hit) begin
            // A load in EX is the newer writer, MEM value is stale then
            res = {1'b1, mem_fwd_data_i};
        end
        return res;
    endfunction

    always_comb begin
        {rs1_ready, rs1_data_o} = pick_operand(rd_rs1_en_i, rs1_idx_i,
                                               pend[rs1_idx_i], regs[rs1_idx_i]);
        {rs2_ready, rs2_data_o} = pick_operand(rd_rs2_en_i, rs2_idx_i,
                                               pend[rs2_idx_i], regs[rs2_idx_i]);
    end

    // Missing operand holds issue
    assign stall_o = (rd_rs1_en_i && !rs1_ready) || (rd_rs2_en_i && !rs2_ready);

    // ------------------------------
    // Scoreboard and write port
    // ------------------------------
    // Register 0 never counts and never stores
    assign inc_en  = alloc_en_i && (alloc_rd_i != '0);
    assign dec_en  = wb_en_i && (wb_rd_i != '0);
    assign same_rd = inc_en && dec_en && (alloc_rd_i == wb_rd_i);

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
                pend[i] <= '0;
            end
        end else begin
            if (dec_en) begin
                regs[wb_rd_i] <= wb_data_i;
            end
            // Claim and retire on one register cancel out
            if (inc_en && !same_rd) begin
                pend[alloc_rd_i] <= pend[alloc_rd_i] + 1'b1;
            end
            if (dec_en && !same_rd) begin
                pend[wb_rd_i] <= pend[wb_rd_i] - 1'b1;
            end
        end
    end

    // At most three writers exist between issue and WB
    a_pend_no_overflow: assert property (@(posedge clk_i) disable iff (!rst_i)
        (inc_en && !same_rd) |-> (pend[alloc_rd_i] != '1));

    // Every retire matches an earlier claim
    a_pend_no_underflow: assert property (@(posedge clk_i) disable iff (!rst_i)
        (dec_en && !same_rd) |-> (pend[wb_rd_i] != '0));

endmodule

// File: source/issue_stage.sv
module issue_stage
    import pipe_regfile_pkg::*;
(
    input  logic                  clk_i,
    input  logic                  rst_i,
    input  logic                  head_valid_i,
    input  opcode_e               head_op_i,
    input  logic [REG_ADDR_W-1:0] head_rd_i,
    input  logic [REG_ADDR_W-1:0] head_rs1_i,
    input  logic [REG_ADDR_W-1:0] head_rs2_i,
    input  logic [IMM_W-1:0]      head_imm_i,
    output logic                  pop_o,
    output logic                  rd_rs1_en_o,
    output logic                  rd_rs2_en_o,
    output logic [REG_ADDR_W-1:0] rs1_idx_o,
    output logic [REG_ADDR_W-1:0] rs2_idx_o,
    input  logic [XLEN-1:0]       rs1_data_i,
    input  logic [XLEN-1:0]       rs2_data_i,
    input  logic                  stall_i,
    output logic                  alloc_en_o,
    output logic [REG_ADDR_W-1:0] alloc_rd_o,
    output logic                  iss_valid_o,
    output opcode_e               iss_op_o,
    output logic [REG_ADDR_W-1:0] iss_rd_o,
    output logic [XLEN-1:0]       iss_a_o,
    output logic [XLEN-1:0]       iss_b_o,
    output logic [IMM_W-1:0]      iss_imm_o
);

    logic uses_rs1;
    logic uses_rs2;
    logic fire;

    // ------------------------------
    // Source operand decode
    // ------------------------------
    always_comb begin
        uses_rs1 = 1'b0;
        uses_rs2 = 1'b0;
        case (head_op_i)
            OP_ADD, OP_SUB, OP_AND, OP_XOR, OP_STORE: begin
                uses_rs1 = 1'b1;
                uses_rs2 = 1'b1;
            end
            // Base register only
            OP_ADDI, OP_LOAD: begin
                uses_rs1 = 1'b1;
            end
            default: begin
                uses_rs1 = 1'b0;
            end
        endcase
    end

    // Operand requests go out whenever a head is present
    assign rd_rs1_en_o = head_valid_i && uses_rs1;
    assign rd_rs2_en_o = head_valid_i && uses_rs2;
    assign rs1_idx_o   = head_rs1_i;
    assign rs2_idx_o   = head_rs2_i;

    // Launch only with all operands in hand
    assign fire  = head_valid_i && !stall_i;
    assign pop_o = fire;

    // Scoreboard claim for the destination
    assign alloc_en_o = fire && op_writes_rd(head_op_i);
    assign alloc_rd_o = head_rd_i;

    // ------------------------------
    // Launch into execute
    // ------------------------------
    // Bubble is a NOP with valid low
    assign iss_valid_o = fire;
    assign iss_op_o    = fire ? head_op_i : OP_NOP;
    assign iss_rd_o    = head_rd_i;
    assign iss_a_o     = rs1_data_i;
    assign iss_b_o     = rs2_data_i;
    assign iss_imm_o   = head_imm_i;

    // Stalled head is held by the queue into the next cycle
    a_stall_holds_head: assert property (@(posedge clk_i) disable iff (!rst_i)
        (head_valid_i && stall_i) |=> head_valid_i);

endmodule

// File: source/instr_queue.sv
module instr_queue
    import pipe_regfile_pkg::*;
(
    input  logic                  clk_i,
    input  logic                  rst_i,
    input  logic                  in_valid_i,
    input  opcode_e               in_op_i,
    input  logic [REG_ADDR_W-1:0] in_rd_i,
    input  logic [REG_ADDR_W-1:0] in_rs1_i,
    input  logic [REG_ADDR_W-1:0] in_rs2_i,
    input  logic [IMM_W-1:0]      in_imm_i,
    input  logic                  pop_i,
    output logic                  head_valid_o,
    output opcode_e               head_op_o,
    output logic [REG_ADDR_W-1:0] head_rd_o,
    output logic [REG_ADDR_W-1:0] head_rs1_o,
    output logic [REG_ADDR_W-1:0] head_rs2_o,
    output logic [IMM_W-1:0]      head_imm_o,
    output logic                  credit_o
);

    // Entry payload
    opcode_e                op_q  [QUEUE_DEPTH];
    logic [REG_ADDR_W-1:0]  rd_q  [QUEUE_DEPTH];
    logic [REG_ADDR_W-1:0]  rs1_q [QUEUE_DEPTH];
    logic [REG_ADDR_W-1:0]  rs2_q [QUEUE_DEPTH];
    logic [IMM_W-1:0]       imm_q [QUEUE_DEPTH];

    logic [QUEUE_PTR_W-1:0] wr_ptr;
    logic [QUEUE_PTR_W-1:0] rd_ptr;
    queue_state_e           state;
    queue_state_e           state_next;

    // ------------------------------
    // Occupancy tracking
    // ------------------------------
    always_comb begin
        state_next = state;
        // Push alone fills, pop alone drains, both keep level
        if (in_valid_i && !pop_i) begin
            state_next = (QUEUE_PTR_W'(wr_ptr + 1'b1) == rd_ptr) ? Q_FULL : Q_PARTIAL;
        end else if (pop_i && !in_valid_i) begin
            state_next = (QUEUE_PTR_W'(rd_ptr + 1'b1) == wr_ptr) ? Q_EMPTY : Q_PARTIAL;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            state    <= Q_EMPTY;
            credit_o <= 1'b0;
        end else begin
            if (in_valid_i) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop_i) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            state    <= state_next;
            // One credit back per freed slot, a cycle late
            credit_o <= pop_i;
        end
    end

    // Storage write
    always_ff @(posedge clk_i) begin
        if (in_valid_i) begin
            op_q[wr_ptr]  <= in_op_i;
            rd_q[wr_ptr]  <= in_rd_i;
            rs1_q[wr_ptr] <= in_rs1_i;
            rs2_q[wr_ptr] <= in_rs2_i;
            imm_q[wr_ptr] <= in_imm_i;
        end
    end

    // Head seen by issue without delay
    assign head_valid_o = (state != Q_EMPTY);
    assign head_op_o    = op_q[rd_ptr];
    assign head_rd_o    = rd_q[rd_ptr];
    assign head_rs1_o   = rs1_q[rd_ptr];
    assign head_rs2_o   = rs2_q[rd_ptr];
    assign head_imm_o   = imm_q[rd_ptr];

    // Credit discipline at the source
    a_no_push_full: assert property (@(posedge clk_i) disable iff (!rst_i)
        (state == Q_FULL) |-> !in_valid_i);

    a_no_pop_empty: assert property (@(posedge clk_i) disable iff (!rst_i)
        (state == Q_EMPTY) |-> !pop_i);

endmodule

// File: source/pipe_regfile_pkg.sv
package pipe_regfile_pkg;

    // ------------------------------
    // Datapath widths
    // ------------------------------
    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 32;
    localparam int IMM_W      = 12;

    // Pending writes live in EX, MEM and WB at most
    localparam int PEND_W     = 2;

    // ------------------------------
    // Queue and scratch memory
    // ------------------------------
    // Queue depth doubles as the source's starting credit
    localparam int QUEUE_DEPTH = 4;
    localparam int QUEUE_PTR_W = 2;

    localparam int MEM_WORDS  = 16;
    localparam int MEM_ADDR_W = 4;

    // ------------------------------
    // Encodings
    // ------------------------------
    typedef enum logic [2:0] {
        OP_NOP   = 3'd0,
        OP_ADD   = 3'd1,
        OP_SUB   = 3'd2,
        OP_AND   = 3'd3,
        OP_XOR   = 3'd4,
        OP_ADDI  = 3'd5,
        OP_LOAD  = 3'd6,
        OP_STORE = 3'd7
    } opcode_e;

    typedef enum logic [1:0] {
        Q_EMPTY   = 2'd0,
        Q_PARTIAL = 2'd1,
        Q_FULL    = 2'd2
    } queue_state_e;

    // Ops that end with a register write
    function automatic logic op_writes_rd(opcode_e op);
        return (op != OP_NOP) && (op != OP_STORE);
    endfunction

endpackage
